// File: verilog/ppu_reg_pkg.sv
`default_nettype none

// APB side of the background unit.
// The bus is 32 bits wide. The registers are bytes on word addresses.
package ppu_reg_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int APB_ADDR_W = 16;
	localparam int APB_DATA_W = 32;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// 0x0000 up to here is vram, byte per address
	localparam logic [APB_ADDR_W-1:0] VRAM_WINDOW_END = 16'h1FFF;

	localparam logic [APB_ADDR_W-1:0] REG_LCDC = 16'h2000;    // control byte
	localparam logic [APB_ADDR_W-1:0] REG_SCY  = 16'h2004;    // vertical scroll
	localparam logic [APB_ADDR_W-1:0] REG_SCX  = 16'h2008;    // horizontal scroll

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// lcdc bits
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int LCDC_BG_EN    = 0;    // clear forces every pixel to 0
	localparam int LCDC_MAP_SEL  = 3;    // 0 -> map at 0x1800, 1 -> 0x1C00
	localparam int LCDC_DATA_SEL = 4;    // 1 -> unsigned from 0x0000, 0 -> signed around 0x1000

endpackage

`default_nettype wire

// File: verilog/vram_pkg.sv
`default_nettype none

package vram_pkg;

	localparam int VRAM_AW    = 13;
	localparam int VRAM_BYTES = 1 << VRAM_AW;

	localparam int SCREEN_W       = 160;
	localparam int TILES_PER_LINE = 21;    // one extra tile covers the fine scroll
	localparam int LAST_LY        = 153;   // last line number the LCD counter reaches

	localparam logic [VRAM_AW-1:0] MAP_BASE_0 = 13'h1800;
	localparam logic [8:0] SIGNED_TILE_BIAS   = 9'd128;

	// one tile slot is eight clocks
	typedef enum logic [2:0] {
		MAP_RD,
		MAP_WAIT,
		LO_RD,
		LO_WAIT,
		HI_RD,
		HI_WAIT,
		IDLE6,
		LOAD
	} fetch_step_e;

	typedef struct packed {
		logic [1:0] region;     // always 2'b11 for the maps
		logic       map_sel;
		logic [4:0] row;
		logic [4:0] col;
	} map_view_t;

	typedef struct packed {
		logic [8:0] tile_no;    // 0..383, 16 bytes per tile
		logic [2:0] line;
		logic       plane;      // 0 low bits, 1 high bits
	} tile_view_t;

	typedef union packed {
		map_view_t  map;
		tile_view_t tile;
	} vram_addr_u;

endpackage

`default_nettype wire

// File: verilog/bg_apb_regs.sv
`default_nettype none
`timescale 1ns/1ps

module bg_apb_regs
	import ppu_reg_pkg::*;
	import vram_pkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic                  psel,
	input  wire logic                  penable,
	input  wire logic                  pwrite,
	input  wire logic [APB_ADDR_W-1:0] paddr,
	input  wire logic [APB_DATA_W-1:0] pwdata,
	output logic      [APB_DATA_W-1:0] prdata,
	output logic                       pready,
	output logic                       pslverr,
	output logic                       vram_req,
	input  wire logic                  vram_gnt,
	output logic                       vram_we,
	output logic      [VRAM_AW-1:0]    vram_addr,
	output logic      [7:0]            vram_wdata,
	input  wire logic [7:0]            vram_rdata,
	output logic      [7:0]            lcdc,
	output logic      [7:0]            scy,
	output logic      [7:0]            scx
);

	logic access, vram_hit, reg_hit;
	logic gnt_seen;    // port was ours last cycle, rdata is valid now

	assign access   = psel && penable;
	assign vram_hit = paddr <= VRAM_WINDOW_END;
	assign reg_hit  = paddr == REG_LCDC || paddr == REG_SCY || paddr == REG_SCX;

	// request stays up until the grant shows, then wait one cycle for data
	assign vram_req   = access && vram_hit && !gnt_seen;
	assign vram_we    = pwrite;
	assign vram_addr  = paddr[VRAM_AW-1:0];
	assign vram_wdata = pwdata[7:0];

	assign pready  = vram_hit ? gnt_seen : 1'b1;
	assign pslverr = access && !vram_hit && !reg_hit;

	always_comb begin
		prdata = '0;
		if (vram_hit) begin
			prdata[7:0] = vram_rdata;
		end else begin
			case (paddr)
				REG_LCDC: prdata[7:0] = lcdc;
				REG_SCY:  prdata[7:0] = scy;
				REG_SCX:  prdata[7:0] = scx;
				default:  prdata = '0;    // unmapped reads as zero
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lcdc     <= '0;
			scy      <= '0;
			scx      <= '0;
			gnt_seen <= 1'b0;
		end else begin
			gnt_seen <= vram_gnt;
			if (access && pwrite) begin
				case (paddr)
					REG_LCDC: lcdc <= pwdata[7:0];
					REG_SCY:  scy  <= pwdata[7:0];
					REG_SCX:  scx  <= pwdata[7:0];
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/bg_fetch_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module bg_fetch_ctrl
	import vram_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic       line_start,
	input  wire logic [7:0] ly,
	input  wire logic [7:0] lcdc,
	input  wire logic [7:0] scy,
	input  wire logic [7:0] scx,
	input  wire logic       vram_req,
	output logic            vram_gnt,
	output fetch_step_e     step,
	output logic [4:0]      tile_x,
	output logic [7:0]      line_scy,
	output logic [7:0]      line_scx,
	output logic [7:0]      line_lcdc,
	output logic            shift_en,
	output logic            load,
	output logic            pixel_valid,
	output logic            line_done
);

	logic       fetching;      // tile slots 0..20 in flight
	logic       shifting;      // shifter holds pixels of this line
	logic       line_active;
	logic       start;
	logic       last_slot;
	logic       last_pixel;
	logic [2:0] discard;       // fine scroll pixels still to drop
	logic [7:0] pix_cnt;

	assign line_active = fetching || shifting;
	// lines past the last LCD row never start a fetch
	assign start       = line_start && !line_active && ly <= 8'(LAST_LY);
	assign last_slot   = tile_x == 5'(TILES_PER_LINE - 1);

	assign load        = fetching && step == LOAD;
	assign shift_en    = shifting;
	assign pixel_valid = shifting && discard == 3'd0;
	assign last_pixel  = pixel_valid && pix_cnt == 8'(SCREEN_W - 1);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per-line settings and the tile slot sequencer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			line_scy  <= '0;
			line_scx  <= '0;
			line_lcdc <= '0;
		end else if (start) begin
			line_scy  <= scy;
			line_scx  <= scx;
			line_lcdc <= lcdc;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetching <= 1'b0;
			step     <= MAP_RD;
			tile_x   <= '0;
		end else if (start) begin
			fetching <= 1'b1;
			step     <= MAP_RD;      // slot 0 begins on cycle 1
			tile_x   <= '0;
		end else if (fetching) begin
			step <= fetch_step_e'(step + 3'd1);    // LOAD wraps back to MAP_RD
			if (step == LOAD) begin
				if (last_slot)
					fetching <= 1'b0;
				else
					tile_x <= tile_x + 5'd1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pixel counting
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shifting  <= 1'b0;
			discard   <= '0;
			pix_cnt   <= '0;
			line_done <= 1'b0;
		end else begin
			line_done <= last_pixel;
			if (start) begin
				discard <= scx[2:0];
				pix_cnt <= '0;
			end else if (load && tile_x == '0) begin
				shifting <= 1'b1;     // first tile goes in at end of cycle 8
			end else if (shifting) begin
				if (discard != 3'd0)
					discard <= discard - 3'd1;
				else if (last_pixel)
					shifting <= 1'b0;
				else
					pix_cnt <= pix_cnt + 8'd1;
			end
		end
	end

	// host gets the ram port only between lines, one cycle after asking
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			vram_gnt <= 1'b0;
		else
			vram_gnt <= vram_req && !vram_gnt && !line_active && !start;
	end

endmodule

`default_nettype wire

// File: verilog/bg_map_addr.sv
`default_nettype none
`timescale 1ns/1ps

module bg_map_addr
	import ppu_reg_pkg::*;
	import vram_pkg::*;
(
	input  wire logic [7:0]  ly,
	input  wire logic [4:0]  tile_x,
	input  wire logic [7:0]  line_scy,
	input  wire logic [7:0]  line_scx,
	input  wire logic [7:0]  line_lcdc,
	input  wire fetch_step_e step,
	input  wire logic [7:0]  tile_num,
	output vram_addr_u       fetch_addr
);

	logic [7:0] bg_y;       // line in the 256x256 map
	logic [7:0] bg_x;       // left column of the tile being fetched
	logic [8:0] eff_tile;

	// scroll adders, both wrap at 256
	assign bg_y = ly + line_scy;
	assign bg_x = {tile_x, 3'b000} + line_scx;

	// signed mode: tile 0 sits at 0x1000, -128 at 0x0800
	always_comb begin
		if (line_lcdc[LCDC_DATA_SEL])
			eff_tile = {1'b0, tile_num};
		else
			eff_tile = {1'b0, ~tile_num[7], tile_num[6:0]} + SIGNED_TILE_BIAS;
	end

	always_comb begin
		fetch_addr = '0;
		if (step == MAP_RD) begin
			fetch_addr.map.region  = MAP_BASE_0[VRAM_AW-1 -: 2];
			fetch_addr.map.map_sel = line_lcdc[LCDC_MAP_SEL];
			fetch_addr.map.row     = bg_y[7:3];
			fetch_addr.map.col     = bg_x[7:3];
		end else begin
			fetch_addr.tile.tile_no = eff_tile;
			fetch_addr.tile.line    = bg_y[2:0];
			fetch_addr.tile.plane   = step == HI_RD;    // only the read steps matter
		end
	end

endmodule

`default_nettype wire

// File: verilog/bg_pixel_shifter.sv
`default_nettype none
`timescale 1ns/1ps

module bg_pixel_shifter
	import vram_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire fetch_step_e step,
	input  wire logic [7:0]  rdata,
	input  wire logic        load,
	input  wire logic        shift_en,
	input  wire logic        bg_en,
	output logic [7:0]       tile_num,
	output logic [1:0]       pixel
);

	logic [7:0] lo_byte;
	logic [7:0] hi_byte;
	logic [7:0] lo_sr;
	logic [7:0] hi_sr;

	// data of each read step is on rdata during the wait step that follows
	always_ff @(posedge clk) begin
		case (step)
			MAP_WAIT: tile_num <= rdata;
			LO_WAIT:  lo_byte  <= rdata;
			HI_WAIT:  hi_byte  <= rdata;
			default: ;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// two-plane shift register, leftmost pixel in bit 7
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lo_sr <= '0;
			hi_sr <= '0;
		end else if (load) begin
			lo_sr <= lo_byte;    // previous tile is fully out by now
			hi_sr <= hi_byte;
		end else if (shift_en) begin
			lo_sr <= {lo_sr[6:0], 1'b0};
			hi_sr <= {hi_sr[6:0], 1'b0};
		end
	end

	assign pixel = bg_en ? {hi_sr[7], lo_sr[7]} : 2'b00;

endmodule

`default_nettype wire

// File: verilog/vram.sv
`default_nettype none
`timescale 1ns/1ps

// 8 KiB video ram, one port shared by host and fetcher
module vram
	import vram_pkg::*;
(
	input  wire logic               clk,
	input  wire logic               we,
	input  wire logic [VRAM_AW-1:0] addr,
	input  wire logic [7:0]         wdata,
	output logic      [7:0]         rdata
);

	logic [7:0] mem [VRAM_BYTES];

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
	end

	// registered read, old contents on a same-cycle write
	always_ff @(posedge clk) begin
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// File: verilog/bg_top.sv
`default_nettype none
`timescale 1ns/1ps

module bg_top
	import ppu_reg_pkg::*;
	import vram_pkg::*;
(
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire logic                  psel,
	input  wire logic                  penable,
	input  wire logic                  pwrite,
	input  wire logic [APB_ADDR_W-1:0] paddr,
	input  wire logic [APB_DATA_W-1:0] pwdata,
	output logic      [APB_DATA_W-1:0] prdata,
	output logic                       pready,
	output logic                       pslverr,
	input  wire logic                  line_start,
	input  wire logic [7:0]            ly,
	output logic      [1:0]            pixel,
	output logic                       pixel_valid,
	output logic                       line_done
);

	logic               vram_req, vram_gnt;
	logic               host_we;
	logic [VRAM_AW-1:0] host_addr;
	logic [7:0]         host_wdata;
	logic [7:0]         ram_rdata;
	logic               ram_we;
	logic [VRAM_AW-1:0] ram_addr;
	logic [7:0]         lcdc, scy, scx;
	logic [7:0]         line_scy, line_scx, line_lcdc;
	fetch_step_e        step;
	logic [4:0]         tile_x;
	logic               shift_en, load;
	logic [7:0]         tile_num;
	vram_addr_u         fetch_addr;

	// grant hands the ram port to the host for one cycle
	assign ram_we   = vram_gnt && host_we;
	assign ram_addr = vram_gnt ? host_addr : fetch_addr;

	bg_apb_regs u_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.vram_req   (vram_req),
		.vram_gnt   (vram_gnt),
		.vram_we    (host_we),
		.vram_addr  (host_addr),
		.vram_wdata (host_wdata),
		.vram_rdata (ram_rdata),
		.lcdc       (lcdc),
		.scy        (scy),
		.scx        (scx)
	);

	bg_fetch_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.line_start  (line_start),
		.ly          (ly),
		.lcdc        (lcdc),
		.scy         (scy),
		.scx         (scx),
		.vram_req    (vram_req),
		.vram_gnt    (vram_gnt),
		.step        (step),
		.tile_x      (tile_x),
		.line_scy    (line_scy),
		.line_scx    (line_scx),
		.line_lcdc   (line_lcdc),
		.shift_en    (shift_en),
		.load        (load),
		.pixel_valid (pixel_valid),
		.line_done   (line_done)
	);

	bg_map_addr u_addr (
		.ly         (ly),
		.tile_x     (tile_x),
		.line_scy   (line_scy),
		.line_scx   (line_scx),
		.line_lcdc  (line_lcdc),
		.step       (step),
		.tile_num   (tile_num),
		.fetch_addr (fetch_addr)
	);

	bg_pixel_shifter u_shift (
		.clk      (clk),
		.rst_n    (rst_n),
		.step     (step),
		.rdata    (ram_rdata),
		.load     (load),
		.shift_en (shift_en),
		.bg_en    (line_lcdc[LCDC_BG_EN]),
		.tile_num (tile_num),
		.pixel    (pixel)
	);

	vram u_vram (
		.clk   (clk),
		.we    (ram_we),
		.addr  (ram_addr),
		.wdata (host_wdata),
		.rdata (ram_rdata)
	);

endmodule

`default_nettype wire

// File: verification/bg_tb.sv
`default_nettype none
`timescale 1ns/1ps

module bg_tb
	import ppu_reg_pkg::*;
	import vram_pkg::*;
();

	localparam int CLK_PERIOD  = 20;
	localparam int NUM_LINES   = 10;
	localparam int XFER_CYCLES = 8;      // upper bound for one vram transfer
	localparam int LINE_CYCLES = 250;
	localparam int LINE_LIMIT  = 300;    // cycles to wait for line_done or pready
	localparam int WATCHDOG_CYCLES = 2 * VRAM_BYTES * XFER_CYCLES
		+ (NUM_LINES + 4) * LINE_CYCLES + 200;

	logic                  clk;
	logic                  rst_n;
	logic                  psel, penable, pwrite;
	logic [APB_ADDR_W-1:0] paddr;
	logic [APB_DATA_W-1:0] pwdata;
	logic [APB_DATA_W-1:0] prdata;
	logic                  pready, pslverr;
	logic                  line_start;
	logic [7:0]            ly;
	logic [1:0]            pixel;
	logic                  pixel_valid, line_done;

	logic [7:0]  shadow [VRAM_BYTES];     // host-side copy of vram
	logic [39:0] line_table [NUM_LINES];  // lcdc, scy, scx, ly, first valid cycle
	integer      seed;
	time         line_done_at;

	bg_top UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.line_start  (line_start),
		.ly          (ly),
		.pixel       (pixel),
		.pixel_valid (pixel_valid),
		.line_done   (line_done)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// failure handling and compare
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
			stop_with_failure($sformatf("Error at %0d ns: %s, got 0x%0h expected 0x%0h",
				$time, what, got, exp));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// apb master
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic apb_access(input logic wr, input logic [APB_ADDR_W-1:0] addr,
			input logic [APB_DATA_W-1:0] wdata, output logic [APB_DATA_W-1:0] rdata,
			output logic err);
		int waits;
		@(negedge clk);
		psel    = 1'b1;      // setup phase
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		#1;
		waits = 0;
		while (!pready) begin
			@(negedge clk);
			waits++;
			if (waits > LINE_LIMIT)
				stop_with_failure($sformatf("APB access to 0x%04h never saw pready", addr));
		end
		rdata = prdata;
		err   = pslverr;
		@(negedge clk);      // access completed on the rising edge before
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [7:0] data);
		logic [APB_DATA_W-1:0] unused;
		logic                  err;
		apb_access(1'b1, addr, {24'h0, data}, unused, err);
		check(err, 1'b0, "pslverr on write");
	endtask

	task automatic apb_read(input logic [APB_ADDR_W-1:0] addr,
			output logic [APB_DATA_W-1:0] data);
		logic err;
		apb_access(1'b0, addr, '0, data, err);
		check(err, 1'b0, "pslverr on read");
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// background model on the shadow copy
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [1:0] model_pixel(input logic [7:0] m_lcdc,
			input logic [7:0] m_scy, input logic [7:0] m_scx, input logic [7:0] m_ly,
			input int i);
		int         x, y;
		int         map_addr, tile_addr, tile_s;
		logic [7:0] tile, lo, hi;
		if (!m_lcdc[LCDC_BG_EN])
			return 2'b00;
		y = (m_ly + m_scy) % 256;    // both wrap at 256
		x = (m_scx + i) % 256;
		map_addr = (m_lcdc[LCDC_MAP_SEL] ? 7168 : 6144) + (y / 8) * 32 + x / 8;
		tile = shadow[map_addr];
		tile_s = $signed(tile);
		if (m_lcdc[LCDC_DATA_SEL])
			tile_addr = tile * 16;
		else
			tile_addr = 4096 + tile_s * 16;    // signed around 0x1000
		tile_addr = tile_addr + (y % 8) * 2;
		lo = shadow[tile_addr];
		hi = shadow[tile_addr + 1];
		return {hi[7 - x % 8], lo[7 - x % 8]};
	endfunction

	// one line from line_start to line_done, pixels checked as they come
	task automatic run_line(input logic [7:0] l_lcdc, input logic [7:0] l_scy,
			input logic [7:0] l_scx, input logic [7:0] l_ly, input int first_cyc);
		int cyc;
		int n_valid;
		bit done;
		@(negedge clk);
		ly         = l_ly;
		line_start = 1'b1;   // cycle 0
		cyc     = 0;
		n_valid = 0;
		done    = 1'b0;
		while (!done) begin
			@(negedge clk);
			line_start = 1'b0;
			cyc++;
			if (pixel_valid) begin
				if (n_valid == 0)
					check(cyc, first_cyc, "cycle of first valid pixel");
				check(pixel, model_pixel(l_lcdc, l_scy, l_scx, l_ly, n_valid), "pixel value");
				n_valid++;
			end
			if (line_done) begin
				check(n_valid, SCREEN_W, "valid pixel count");
				check(cyc, first_cyc + SCREEN_W, "cycle of line_done");
				line_done_at = $time;
				done = 1'b1;
			end else if (cyc > LINE_LIMIT) begin
				stop_with_failure($sformatf("no line_done within %0d cycles of line_start",
					LINE_LIMIT));
			end
		end
		@(negedge clk);
		check(line_done, 1'b0, "line_done longer than one cycle");
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		logic [APB_DATA_W-1:0] rd;
		logic                  err;
		logic [39:0]           e;
		time                   xfer_at;
		rst_n        = 1'b0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		line_start   = 1'b0;
		ly           = '0;
		seed         = 76967;
		line_done_at = 0;

		line_table[0] = {8'h11, 8'h00, 8'h00, 8'd0,   8'd9};     // map 0, unsigned
		line_table[1] = {8'h19, 8'h00, 8'h00, 8'd17,  8'd9};     // map 1, unsigned
		line_table[2] = {8'h01, 8'h00, 8'h00, 8'd40,  8'd9};     // map 0, signed
		line_table[3] = {8'h09, 8'h00, 8'h00, 8'd153, 8'd9};     // map 1, signed
		line_table[4] = {8'h11, 8'h10, 8'h18, 8'd33,  8'd9};     // coarse only
		line_table[5] = {8'h19, 8'h03, 8'h05, 8'd100, 8'd14};
		line_table[6] = {8'h01, 8'hC8, 8'hFA, 8'd150, 8'd11};    // y and x both wrap
		line_table[7] = {8'h09, 8'hFF, 8'h67, 8'd1,   8'd16};
		line_table[8] = {8'h10, 8'h07, 8'h03, 8'd60,  8'd12};    // bg off
		line_table[9] = {8'h00, 8'h00, 8'h00, 8'd2,   8'd9};

		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check(pixel_valid, 1'b0, "pixel_valid after reset");
		check(line_done, 1'b0, "line_done after reset");
		check(pslverr, 1'b0, "pslverr after reset");
		check(pready, 1'b0, "pready for vram after reset");

		// registers
		apb_read(REG_LCDC, rd);
		check(rd, 32'h0, "lcdc reset value");
		apb_read(REG_SCY, rd);
		check(rd, 32'h0, "scy reset value");
		apb_read(REG_SCX, rd);
		check(rd, 32'h0, "scx reset value");
		apb_write(REG_LCDC, 8'hA5);
		apb_write(REG_SCY, 8'h3C);
		apb_write(REG_SCX, 8'hF0);
		apb_read(REG_LCDC, rd);
		check(rd, 32'hA5, "lcdc read-back");
		apb_read(REG_SCY, rd);
		check(rd, 32'h3C, "scy read-back");
		apb_read(REG_SCX, rd);
		check(rd, 32'hF0, "scx read-back");
		apb_access(1'b0, 16'h200C, '0, rd, err);
		check(err, 1'b1, "pslverr on unmapped read");
		check(rd, 32'h0, "unmapped read data");
		apb_access(1'b1, 16'h3000, 32'h5A, rd, err);
		check(err, 1'b1, "pslverr on unmapped write");
		check(rd, 32'h0, "prdata on unmapped write");

		// vram fill and read-back through the wait-state handshake
		for (int a = 0; a < VRAM_BYTES; a++) begin
			shadow[a] = $random(seed);
			apb_write(a[APB_ADDR_W-1:0], shadow[a]);
		end
		for (int a = 0; a < VRAM_BYTES; a++) begin
			apb_read(a[APB_ADDR_W-1:0], rd);
			check(rd, {24'h0, shadow[a]}, "vram read-back");
		end

		for (int n = 0; n < NUM_LINES; n++) begin
			e = line_table[n];
			apb_write(REG_LCDC, e[39:32]);
			apb_write(REG_SCY, e[31:24]);
			apb_write(REG_SCX, e[23:16]);
			run_line(e[39:32], e[31:24], e[23:16], e[15:8], e[7:0]);
		end

		// register writes mid-line land on the next line
		apb_write(REG_LCDC, 8'h19);
		apb_write(REG_SCY, 8'h03);
		apb_write(REG_SCX, 8'h05);
		fork
			run_line(8'h19, 8'h03, 8'h05, 8'd70, 14);
			begin
				repeat (60) @(negedge clk);
				apb_write(REG_SCX, 8'h4B);
				apb_write(REG_LCDC, 8'h01);
			end
		join
		run_line(8'h01, 8'h03, 8'h4B, 8'd71, 12);

		// host vram read held off until the line ends
		fork
			run_line(8'h01, 8'h03, 8'h4B, 8'd72, 12);
			begin
				repeat (30) @(negedge clk);
				apb_read(16'h1234, rd);
				xfer_at = $time;
			end
		join
		check(rd, {24'h0, shadow[16'h1234]}, "vram read during a line");
		check(xfer_at > line_done_at, 1'b1, "vram access completed before line_done");

		$display("Simulation PASSED");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		stop_with_failure($sformatf("run timed out after %0d clock cycles", WATCHDOG_CYCLES));
	end

endmodule

`default_nettype wire

// File: bg_ppu.f
verilog/ppu_reg_pkg.sv
verilog/vram_pkg.sv
verilog/bg_apb_regs.sv
verilog/bg_fetch_ctrl.sv
verilog/bg_map_addr.sv
verilog/bg_pixel_shifter.sv
verilog/vram.sv
verilog/bg_top.sv
verification/bg_tb.sv

// File: Bender.yml
package:
  name: bg_ppu

sources:
  - files:
      - verilog/ppu_reg_pkg.sv
      - verilog/vram_pkg.sv
      - verilog/bg_apb_regs.sv
      - verilog/bg_fetch_ctrl.sv
      - verilog/bg_map_addr.sv
      - verilog/bg_pixel_shifter.sv
      - verilog/vram.sv
      - verilog/bg_top.sv
  - target: test
    files:
      - verification/bg_tb.sv
